// File: compile.f
src/csrPkg.sv
src/csrMachine.sv
src/csrStatus.sv
src/csrBusSlave.sv
src/csrUnit.sv
test/csrUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module csrUnitTb \
  -f compile.f -o csrUnitSim

# A failing run exits nonzero, so carry on to the log check
./obj_dir/csrUnitSim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: src/csrBusSlave.sv
// Wishbone CSR slave
`timescale 1ns/1ps
`default_nettype none

module csrBusSlave (
  input  wire logic            clk,
  input  wire logic            reset,
  // Wishbone classic slave side
  input  wire logic            cyc,
  input  wire logic            stb,
  input  wire logic            we,
  input  wire csrPkg::csrAddrT adr,
  input  wire csrPkg::xWordT   writeData,
  // Register block results
  input  wire csrPkg::xWordT   machineRead,
  input  wire csrPkg::xWordT   statusRead,
  input  wire logic            machineHit,
  input  wire logic            statusHit,
  // Shared access to both blocks
  output logic                 csrWrite,
  output csrPkg::csrAddrT      csrAddr,
  output csrPkg::xWordT        csrWriteData,
  // Response
  output csrPkg::xWordT        readData,
  output logic                 ack,
  output logic                 err
);

  csrPkg::busStateT state;

  logic          request;
  logic          readOnly;
  logic          claimed;
  logic          badAccess;
  csrPkg::xWordT combinedRead;

  //////////////////////////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////////////////////////

  // Only one request in flight
  assign request = cyc && stb && (state == csrPkg::busIdle);

  // Top two address bits set marks the read-only range
  assign readOnly = (adr[11:10] == 2'b11);

  assign claimed   = machineHit || statusHit;
  assign badAccess = !claimed || (we && readOnly);

  // Blocks decode their own addresses
  assign csrAddr      = adr;
  assign csrWriteData = writeData;

  // A failing request must not touch any register
  assign csrWrite = request && we && !readOnly && claimed;

  // Blocks return zero when they miss
  always_comb begin
    combinedRead = '0;
    if (machineHit)
      combinedRead = combinedRead | machineRead;
    if (statusHit)
      combinedRead = combinedRead | statusRead;
  end

  //////////////////////////////////////////////////////////////////////
  // Response FSM
  //////////////////////////////////////////////////////////////////////

  // Respond for one cycle then go back to idle
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= csrPkg::busIdle;
      ack   <= 1'b0;
      err   <= 1'b0;
    end else begin
      case (state)
        csrPkg::busIdle: begin
          if (request) begin
            state <= csrPkg::busRespond;
            ack   <= !badAccess;
            err   <= badAccess;
          end
        end
        csrPkg::busRespond: begin
          state <= csrPkg::busIdle;
          ack   <= 1'b0;
          err   <= 1'b0;
        end
        default: begin
          state <= csrPkg::busIdle;
          ack   <= 1'b0;
          err   <= 1'b0;
        end
      endcase
    end
  end

  // Read value from before any write in the same cycle
  always_ff @(posedge clk) begin
    if (request)
      readData <= combinedRead;
  end

endmodule

`default_nettype wire

// File: src/csrMachine.sv
// Machine trap and identity registers
`timescale 1ns/1ps
`default_nettype none

module csrMachine (
  input  wire logic           clk,
  input  wire logic           reset,
  input  wire logic           csrWrite,
  input  wire csrPkg::csrAddrT csrAddr,
  input  wire csrPkg::xWordT  csrWriteData,
  input  wire logic           trap,
  input  wire csrPkg::xWordT  trapPc,
  input  wire csrPkg::xWordT  trapCause,
  input  wire csrPkg::xWordT  trapValue,
  output csrPkg::xWordT       readValue,
  output logic                hit,
  output csrPkg::xWordT       trapVector,
  output csrPkg::xWordT       returnPc
);

  // Register state
  csrPkg::xWordT mtvec;
  csrPkg::xWordT mepc;
  csrPkg::xWordT mcause;
  csrPkg::xWordT mtval;
  csrPkg::xWordT mscratch;
  csrPkg::xWordT medeleg;
  csrPkg::xWordT mideleg;
  csrPkg::xWordT mcounteren;
  csrPkg::xWordT mcountinhibit;

  // Per-register bus write strobes
  logic writeMtvec;
  logic writeMepc;
  logic writeMcause;
  logic writeMtval;
  logic writeMscratch;
  logic writeMedeleg;
  logic writeMideleg;
  logic writeMcounteren;
  logic writeMcountinhibit;

  //////////////////////////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////////////////////////

  assign writeMtvec         = csrWrite && (csrAddr == csrPkg::addrMtvec);
  assign writeMepc          = csrWrite && (csrAddr == csrPkg::addrMepc);
  assign writeMcause        = csrWrite && (csrAddr == csrPkg::addrMcause);
  assign writeMtval         = csrWrite && (csrAddr == csrPkg::addrMtval);
  assign writeMscratch      = csrWrite && (csrAddr == csrPkg::addrMscratch);
  assign writeMedeleg       = csrWrite && (csrAddr == csrPkg::addrMedeleg);
  assign writeMideleg       = csrWrite && (csrAddr == csrPkg::addrMideleg);
  assign writeMcounteren    = csrWrite && (csrAddr == csrPkg::addrMcounteren);
  assign writeMcountinhibit = csrWrite && (csrAddr == csrPkg::addrMcountinhibit);

  //////////////////////////////////////////////////////////////////////
  // Trap setup registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mtvec         <= csrPkg::resetVector;
      mscratch      <= '0;
      medeleg       <= '0;
      mideleg       <= '0;
      // Counters enabled and inhibited out of reset
      mcounteren    <= '1;
      mcountinhibit <= '1;
    end else begin
      if (writeMtvec)
        mtvec <= csrWriteData;
      if (writeMscratch)
        mscratch <= csrWriteData;
      // Delegation bits that cannot be set stay zero
      if (writeMedeleg)
        medeleg <= csrWriteData & csrPkg::medelegMask;
      if (writeMideleg)
        mideleg <= csrWriteData & csrPkg::midelegMask;
      if (writeMcounteren)
        mcounteren <= csrWriteData;
      if (writeMcountinhibit)
        mcountinhibit <= csrWriteData;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Trap capture registers
  //////////////////////////////////////////////////////////////////////

  // A trap overrides a bus write to the same register in that cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (trap) begin
      mepc   <= trapPc;
      mcause <= trapCause;
      mtval  <= trapValue;
    end else begin
      if (writeMepc)
        mepc <= csrWriteData;
      if (writeMcause)
        mcause <= csrWriteData;
      if (writeMtval)
        mtval <= csrWriteData;
    end
  end

  // Pipeline sees the live vector and return address
  assign trapVector = mtvec;
  assign returnPc   = mepc;

  //////////////////////////////////////////////////////////////////////
  // Read select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hit = 1'b1;
    case (csrAddr)
      csrPkg::addrMisa:          readValue = csrPkg::misaValue;
      // Vendor, architecture and hart ids are all zero
      csrPkg::addrMvendorid:     readValue = '0;
      csrPkg::addrMarchid:       readValue = '0;
      csrPkg::addrMimpid:        readValue = csrPkg::mimpidValue;
      csrPkg::addrMhartid:       readValue = '0;
      csrPkg::addrMtvec:         readValue = mtvec;
      csrPkg::addrMedeleg:       readValue = medeleg;
      csrPkg::addrMideleg:       readValue = mideleg;
      csrPkg::addrMcounteren:    readValue = mcounteren;
      csrPkg::addrMcountinhibit: readValue = mcountinhibit;
      csrPkg::addrMscratch:      readValue = mscratch;
      csrPkg::addrMepc:          readValue = mepc;
      csrPkg::addrMcause:        readValue = mcause;
      csrPkg::addrMtval:         readValue = mtval;
      default: begin
        // Not ours, the status block or nobody claims it
        readValue = '0;
        hit       = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/csrPkg.sv
// Machine CSR definitions
`default_nettype none

package csrPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and word types
  //////////////////////////////////////////////////////////////////////

  // Hart data width, fixed at RV32
  localparam int xLen = 32;

  // Any CSR value, program counter or bus data word
  typedef logic [xLen-1:0] xWordT;

  // CSR address space is 4096 entries
  typedef logic [11:0] csrAddrT;

  //////////////////////////////////////////////////////////////////////
  // Machine CSR addresses
  //////////////////////////////////////////////////////////////////////

  // Identity registers sit in the read-only range (bits 11:10 set)
  localparam csrAddrT addrMvendorid     = 12'hF11;
  localparam csrAddrT addrMarchid       = 12'hF12;
  localparam csrAddrT addrMimpid        = 12'hF13;
  localparam csrAddrT addrMhartid       = 12'hF14;

  // Trap setup
  localparam csrAddrT addrMstatus       = 12'h300;
  localparam csrAddrT addrMisa          = 12'h301;
  localparam csrAddrT addrMedeleg       = 12'h302;
  localparam csrAddrT addrMideleg       = 12'h303;
  localparam csrAddrT addrMie           = 12'h304;
  localparam csrAddrT addrMtvec         = 12'h305;
  localparam csrAddrT addrMcounteren    = 12'h306;
  localparam csrAddrT addrMcountinhibit = 12'h320;

  // Trap handling
  localparam csrAddrT addrMscratch      = 12'h340;
  localparam csrAddrT addrMepc          = 12'h341;
  localparam csrAddrT addrMcause        = 12'h342;
  localparam csrAddrT addrMtval         = 12'h343;
  localparam csrAddrT addrMip           = 12'h344;

  //////////////////////////////////////////////////////////////////////
  // Reset values, write masks and hardwired values
  //////////////////////////////////////////////////////////////////////

  // Trap vector after reset
  localparam xWordT resetVector = 32'h0000_0000;

  // medeleg bit 11 (ecall from M-mode) can never be delegated
  localparam xWordT medelegMask = ~(xWordT'(1) << 11);

  // Supervisor interrupts only
  localparam xWordT midelegMask = 32'h0000_0222;

  // MSIE, MTIE and MEIE
  localparam xWordT mieMask = 32'h0000_0888;

  // MXL = 1 for RV32, with the I and M extension letters
  localparam xWordT misaValue = 32'h4000_1100;

  // Pipelined implementation id
  localparam xWordT mimpidValue = 32'h0000_0100;

  //////////////////////////////////////////////////////////////////////
  // Field positions
  //////////////////////////////////////////////////////////////////////

  // mstatus fields kept by the status block
  localparam int statusMie  = 3;
  localparam int statusMpie = 7;
  // Low bit of the two-bit MPP field at 12:11
  localparam int statusMpp  = 11;

  // Machine privilege encoding for MPP
  localparam logic [1:0] privMachine = 2'b11;

  // mip bits fed by the irq lines
  localparam int ipMsip = 3;
  localparam int ipMtip = 7;
  localparam int ipMeip = 11;

  // Wishbone slave FSM
  typedef enum logic {
    busIdle,
    busRespond
  } busStateT;

endpackage

`default_nettype wire

// File: src/csrStatus.sv
// Machine status and interrupt registers
`timescale 1ns/1ps
`default_nettype none

module csrStatus (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            csrWrite,
  input  wire csrPkg::csrAddrT csrAddr,
  input  wire csrPkg::xWordT   csrWriteData,
  input  wire logic            trap,
  input  wire logic            mret,
  input  wire logic [2:0]      irq,
  output csrPkg::xWordT        readValue,
  output logic                 hit,
  output logic                 interruptPending
);

  // Kept mstatus fields
  logic       mstatusMie;
  logic       mstatusMpie;
  logic [1:0] mstatusMpp;

  // Interrupt enable, already masked
  csrPkg::xWordT mieReg;

  // irq lines sampled once per cycle
  logic [2:0] irqSample;

  // Assembled register views
  csrPkg::xWordT mstatusValue;
  csrPkg::xWordT mipValue;

  logic writeMstatus;
  logic writeMie;

  assign writeMstatus = csrWrite && (csrAddr == csrPkg::addrMstatus);
  assign writeMie     = csrWrite && (csrAddr == csrPkg::addrMie);

  //////////////////////////////////////////////////////////////////////
  // mstatus
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mstatusMie  <= 1'b0;
      mstatusMpie <= 1'b0;
      mstatusMpp  <= 2'b00;
    end else if (trap) begin
      // Stack MIE and disable interrupts in the handler
      mstatusMpie <= mstatusMie;
      mstatusMie  <= 1'b0;
      mstatusMpp  <= csrPkg::privMachine;
    end else if (mret) begin
      // Pop the stack
      mstatusMie  <= mstatusMpie;
      mstatusMpie <= 1'b1;
      // Machine is the least privileged mode here
      mstatusMpp  <= csrPkg::privMachine;
    end else if (writeMstatus) begin
      mstatusMie  <= csrWriteData[csrPkg::statusMie];
      mstatusMpie <= csrWriteData[csrPkg::statusMpie];
      mstatusMpp  <= csrWriteData[csrPkg::statusMpp +: 2];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // mie and mip
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mieReg    <= '0;
      irqSample <= 3'b000;
    end else begin
      if (writeMie)
        mieReg <= csrWriteData & csrPkg::mieMask;
      // Writes to mip are accepted and dropped
      irqSample <= irq;
    end
  end

  always_comb begin
    mstatusValue = '0;
    mstatusValue[csrPkg::statusMie]       = mstatusMie;
    mstatusValue[csrPkg::statusMpie]      = mstatusMpie;
    mstatusValue[csrPkg::statusMpp +: 2]  = mstatusMpp;
    // Software, timer and external pending bits
    mipValue = '0;
    mipValue[csrPkg::ipMsip] = irqSample[0];
    mipValue[csrPkg::ipMtip] = irqSample[1];
    mipValue[csrPkg::ipMeip] = irqSample[2];
  end

  // Global enable gates any enabled and pending source
  assign interruptPending = mstatusMie && (|(mipValue & mieReg));

  //////////////////////////////////////////////////////////////////////
  // Read select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hit = 1'b1;
    case (csrAddr)
      csrPkg::addrMstatus: readValue = mstatusValue;
      csrPkg::addrMie:     readValue = mieReg;
      csrPkg::addrMip:     readValue = mipValue;
      default: begin
        readValue = '0;
        hit       = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/csrUnit.sv
// Machine CSR unit top
`timescale 1ns/1ps
`default_nettype none

module csrUnit (
  input  wire logic            clk,
  input  wire logic            reset,
  // Wishbone classic slave
  input  wire logic            cyc,
  input  wire logic            stb,
  input  wire logic            we,
  input  wire csrPkg::csrAddrT adr,
  input  wire csrPkg::xWordT   writeData,
  output csrPkg::xWordT        readData,
  output logic                 ack,
  output logic                 err,
  // Pipeline trap and return
  input  wire logic            trap,
  input  wire csrPkg::xWordT   trapPc,
  input  wire csrPkg::xWordT   trapCause,
  input  wire csrPkg::xWordT   trapValue,
  input  wire logic            mret,
  input  wire logic [2:0]      irq,
  output csrPkg::xWordT        trapVector,
  output csrPkg::xWordT        returnPc,
  output logic                 interruptPending
);

  // Shared write path
  logic            csrWrite;
  csrPkg::csrAddrT csrAddr;
  csrPkg::xWordT   csrWriteData;

  // Read results and address claims
  csrPkg::xWordT machineRead;
  csrPkg::xWordT statusRead;
  logic          machineHit;
  logic          statusHit;

  csrBusSlave busSlave (
    .clk          (clk),
    .reset        (reset),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .adr          (adr),
    .writeData    (writeData),
    .machineRead  (machineRead),
    .statusRead   (statusRead),
    .machineHit   (machineHit),
    .statusHit    (statusHit),
    .csrWrite     (csrWrite),
    .csrAddr      (csrAddr),
    .csrWriteData (csrWriteData),
    .readData     (readData),
    .ack          (ack),
    .err          (err)
  );

  csrMachine machineRegs (
    .clk          (clk),
    .reset        (reset),
    .csrWrite     (csrWrite),
    .csrAddr      (csrAddr),
    .csrWriteData (csrWriteData),
    .trap         (trap),
    .trapPc       (trapPc),
    .trapCause    (trapCause),
    .trapValue    (trapValue),
    .readValue    (machineRead),
    .hit          (machineHit),
    .trapVector   (trapVector),
    .returnPc     (returnPc)
  );

  csrStatus statusRegs (
    .clk              (clk),
    .reset            (reset),
    .csrWrite         (csrWrite),
    .csrAddr          (csrAddr),
    .csrWriteData     (csrWriteData),
    .trap             (trap),
    .mret             (mret),
    .irq              (irq),
    .readValue        (statusRead),
    .hit              (statusHit),
    .interruptPending (interruptPending)
  );

endmodule

`default_nettype wire

// File: test/csrUnitTb.sv
// CSR unit testbench
`timescale 1ns/1ps
`default_nettype none

module csrUnitTb;

  // Roughly four times the length of all tests
  localparam int cycleLimit = 3000;

  logic            clk;
  logic            reset;
  logic            cyc;
  logic            stb;
  logic            we;
  csrPkg::csrAddrT adr;
  csrPkg::xWordT   writeData;
  csrPkg::xWordT   readData;
  logic            ack;
  logic            err;
  logic            trap;
  csrPkg::xWordT   trapPc;
  csrPkg::xWordT   trapCause;
  csrPkg::xWordT   trapValue;
  logic            mret;
  logic [2:0]      irq;
  csrPkg::xWordT   trapVector;
  csrPkg::xWordT   returnPc;
  logic            interruptPending;

  int            cycleCount = 0;
  csrPkg::xWordT lcgState = 32'h5a51;
  // Last word written to mtvec
  csrPkg::xWordT mtvecModel;

  csrUnit dut_i (
    .clk              (clk),
    .reset            (reset),
    .cyc              (cyc),
    .stb              (stb),
    .we               (we),
    .adr              (adr),
    .writeData        (writeData),
    .readData         (readData),
    .ack              (ack),
    .err              (err),
    .trap             (trap),
    .trapPc           (trapPc),
    .trapCause        (trapCause),
    .trapValue        (trapValue),
    .mret             (mret),
    .irq              (irq),
    .trapVector       (trapVector),
    .returnPc         (returnPc),
    .interruptPending (interruptPending)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // Failure reporting and checks
  ////////////////////////////////////////////////////////////////////////

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped");
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
      failRun($sformatf("Run timed out after %0d cycles", cycleCount));
  end

  task automatic checkWord(input string name, input csrPkg::xWordT expected,
                           input csrPkg::xWordT actual);
    if (actual !== expected)
      failRun($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual));
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      failRun($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual));
  endtask

  // LCG with the usual 32-bit constants
  function automatic csrPkg::xWordT nextWord();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Software, timer and external bits of mip and mie
  function automatic csrPkg::xWordT ipWord(input logic [2:0] bits);
    csrPkg::xWordT word;
    word = '0;
    word[csrPkg::ipMsip] = bits[0];
    word[csrPkg::ipMtip] = bits[1];
    word[csrPkg::ipMeip] = bits[2];
    return word;
  endfunction

  function automatic csrPkg::xWordT statusWord(input logic mie, input logic mpie,
                                               input logic [1:0] mpp);
    csrPkg::xWordT word;
    word = '0;
    word[csrPkg::statusMie] = mie;
    word[csrPkg::statusMpie] = mpie;
    word[csrPkg::statusMpp +: 2] = mpp;
    return word;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Bus and pipeline drivers
  ////////////////////////////////////////////////////////////////////////

  // One Wishbone request with an optional trap in the accept cycle
  task automatic busCycle(input logic write, input csrPkg::csrAddrT addr,
                          input csrPkg::xWordT data, input logic withTrap,
                          output csrPkg::xWordT rdata, output logic ackFlag,
                          output logic errFlag);
    @(posedge clk);
    cyc       <= 1'b1;
    stb       <= 1'b1;
    we        <= write;
    adr       <= addr;
    writeData <= data;
    trap      <= withTrap;
    @(posedge clk);
    trap <= 1'b0;
    @(negedge clk);
    // Watchdog bounds this wait
    while (!(ack || err))
      @(negedge clk);
    rdata   = readData;
    ackFlag = ack;
    errFlag = err;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wbWrite(input csrPkg::csrAddrT addr, input csrPkg::xWordT data,
                         output logic ackFlag, output logic errFlag);
    csrPkg::xWordT unused;
    busCycle(1'b1, addr, data, 1'b0, unused, ackFlag, errFlag);
  endtask

  task automatic wbRead(input csrPkg::csrAddrT addr, output csrPkg::xWordT data,
                        output logic ackFlag, output logic errFlag);
    busCycle(1'b0, addr, '0, 1'b0, data, ackFlag, errFlag);
  endtask

  task automatic readExpect(input csrPkg::csrAddrT addr, input string name,
                            input csrPkg::xWordT expected);
    csrPkg::xWordT data;
    logic          ackFlag;
    logic          errFlag;
    wbRead(addr, data, ackFlag, errFlag);
    checkFlag({name, " ack"}, 1'b1, ackFlag);
    checkFlag({name, " err"}, 1'b0, errFlag);
    checkWord(name, expected, data);
  endtask

  task automatic writeExpect(input csrPkg::csrAddrT addr, input string name,
                             input csrPkg::xWordT data);
    logic ackFlag;
    logic errFlag;
    wbWrite(addr, data, ackFlag, errFlag);
    checkFlag({name, " write ack"}, 1'b1, ackFlag);
    checkFlag({name, " write err"}, 1'b0, errFlag);
  endtask

  task automatic expectError(input logic write, input csrPkg::csrAddrT addr,
                             input string name);
    csrPkg::xWordT data;
    logic          ackFlag;
    logic          errFlag;
    busCycle(write, addr, nextWord(), 1'b0, data, ackFlag, errFlag);
    checkFlag({name, " ack"}, 1'b0, ackFlag);
    checkFlag({name, " err"}, 1'b1, errFlag);
  endtask

  task automatic loadTrapInfo(input csrPkg::xWordT pc, input csrPkg::xWordT cause,
                              input csrPkg::xWordT value);
    @(posedge clk);
    trapPc    <= pc;
    trapCause <= cause;
    trapValue <= value;
  endtask

  // Single-cycle pulses that end where outputs are stable
  task automatic pulseTrap();
    @(posedge clk);
    trap <= 1'b1;
    @(posedge clk);
    trap <= 1'b0;
    @(negedge clk);
  endtask

  task automatic pulseMret();
    @(posedge clk);
    mret <= 1'b1;
    @(posedge clk);
    mret <= 1'b0;
    @(negedge clk);
  endtask

  task automatic checkTrapVector();
    @(negedge clk);
    checkWord("trapVector", mtvecModel, trapVector);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////

  task automatic testResetValues();
    @(negedge clk);
    checkFlag("ack", 1'b0, ack);
    checkFlag("err", 1'b0, err);
    checkFlag("interruptPending", 1'b0, interruptPending);
    readExpect(csrPkg::addrMstatus, "mstatus", '0);
    readExpect(csrPkg::addrMisa, "misa", csrPkg::misaValue);
    readExpect(csrPkg::addrMedeleg, "medeleg", '0);
    readExpect(csrPkg::addrMideleg, "mideleg", '0);
    readExpect(csrPkg::addrMie, "mie", '0);
    readExpect(csrPkg::addrMtvec, "mtvec", csrPkg::resetVector);
    readExpect(csrPkg::addrMcounteren, "mcounteren", '1);
    readExpect(csrPkg::addrMcountinhibit, "mcountinhibit", '1);
    readExpect(csrPkg::addrMscratch, "mscratch", '0);
    readExpect(csrPkg::addrMepc, "mepc", '0);
    readExpect(csrPkg::addrMcause, "mcause", '0);
    readExpect(csrPkg::addrMtval, "mtval", '0);
    readExpect(csrPkg::addrMip, "mip", '0);
    readExpect(csrPkg::addrMvendorid, "mvendorid", '0);
    readExpect(csrPkg::addrMarchid, "marchid", '0);
    readExpect(csrPkg::addrMimpid, "mimpid", csrPkg::mimpidValue);
    readExpect(csrPkg::addrMhartid, "mhartid", '0);
    checkTrapVector();
  endtask

  task automatic writeReadBack(input csrPkg::csrAddrT addr, input string name,
                               input csrPkg::xWordT mask);
    csrPkg::xWordT word;
    word = nextWord();
    writeExpect(addr, name, word);
    if (addr == csrPkg::addrMtvec)
      mtvecModel = word;
    readExpect(addr, name, word & mask);
  endtask

  task automatic testMaskedWrite();
    writeReadBack(csrPkg::addrMscratch, "mscratch", '1);
    writeReadBack(csrPkg::addrMtvec, "mtvec", '1);
    writeReadBack(csrPkg::addrMepc, "mepc", '1);
    writeReadBack(csrPkg::addrMcause, "mcause", '1);
    writeReadBack(csrPkg::addrMtval, "mtval", '1);
    writeReadBack(csrPkg::addrMedeleg, "medeleg", csrPkg::medelegMask);
    writeReadBack(csrPkg::addrMideleg, "mideleg", csrPkg::midelegMask);
    writeReadBack(csrPkg::addrMie, "mie", csrPkg::mieMask);
    writeReadBack(csrPkg::addrMcounteren, "mcounteren", '1);
    checkTrapVector();
  endtask

  task automatic testErrors();
    expectError(1'b0, 12'h7A0, "unclaimed read");
    expectError(1'b1, 12'h7A0, "unclaimed write");
    expectError(1'b0, 12'h7A0, "unclaimed read after write");
    // Read-only range rejects writes and keeps its value
    expectError(1'b1, csrPkg::addrMvendorid, "mvendorid write");
    readExpect(csrPkg::addrMvendorid, "mvendorid", '0);
    expectError(1'b1, csrPkg::addrMimpid, "mimpid write");
    readExpect(csrPkg::addrMimpid, "mimpid", csrPkg::mimpidValue);
  endtask

  task automatic testTrapReturn();
    csrPkg::xWordT pc;
    csrPkg::xWordT value;
    csrPkg::xWordT word;
    writeExpect(csrPkg::addrMstatus, "mstatus", statusWord(1'b1, 1'b0, 2'b00));
    readExpect(csrPkg::addrMstatus, "mstatus", statusWord(1'b1, 1'b0, 2'b00));
    pc    = nextWord();
    value = nextWord();
    // Environment call cause
    loadTrapInfo(pc, 32'h0000_000B, value);
    pulseTrap();
    checkWord("returnPc", pc, returnPc);
    readExpect(csrPkg::addrMepc, "mepc", pc);
    readExpect(csrPkg::addrMcause, "mcause", 32'h0000_000B);
    readExpect(csrPkg::addrMtval, "mtval", value);
    readExpect(csrPkg::addrMstatus, "mstatus after trap", statusWord(1'b0, 1'b1, 2'b11));
    pulseMret();
    checkWord("returnPc", pc, returnPc);
    readExpect(csrPkg::addrMstatus, "mstatus after mret", statusWord(1'b1, 1'b1, 2'b11));
    checkTrapVector();
    word = nextWord();
    writeExpect(csrPkg::addrMtvec, "mtvec", word);
    mtvecModel = word;
    checkTrapVector();
  endtask

  // Full sweep of mie bits, global MIE and irq lines
  task automatic testInterruptPending();
    logic expected;
    for (int m = 0; m < 8; m++) begin
      // Bits outside the mask must be dropped
      writeExpect(csrPkg::addrMie, "mie",
                  ipWord(m[2:0]) | (nextWord() & ~csrPkg::mieMask));
      readExpect(csrPkg::addrMie, "mie", ipWord(m[2:0]));
      for (int s = 0; s < 2; s++) begin
        writeExpect(csrPkg::addrMstatus, "mstatus", statusWord(s[0], 1'b0, 2'b00));
        for (int i = 0; i < 8; i++) begin
          @(posedge clk);
          irq <= i[2:0];
          // mip follows irq one cycle later
          @(posedge clk);
          @(negedge clk);
          // Some line both raised and enabled, gated by global MIE
          expected = s[0] && (|(i[2:0] & m[2:0]));
          checkFlag("interruptPending", expected, interruptPending);
          if (m == 0)
            readExpect(csrPkg::addrMip, "mip", ipWord(i[2:0]));
        end
      end
    end
    @(posedge clk);
    irq <= 3'b000;
  endtask

  task automatic testTrapPriority();
    csrPkg::xWordT busWord;
    csrPkg::xWordT pc;
    csrPkg::xWordT data;
    logic          ackFlag;
    logic          errFlag;
    busWord = nextWord();
    pc      = nextWord();
    loadTrapInfo(pc, 32'h0000_0007, nextWord());
    busCycle(1'b1, csrPkg::addrMepc, busWord, 1'b1, data, ackFlag, errFlag);
    checkFlag("mepc write ack", 1'b1, ackFlag);
    checkFlag("mepc write err", 1'b0, errFlag);
    readExpect(csrPkg::addrMepc, "mepc after trap", pc);
    // Unrelated register still takes the bus write
    busWord = nextWord();
    pc      = nextWord();
    loadTrapInfo(pc, 32'h0000_0002, nextWord());
    busCycle(1'b1, csrPkg::addrMscratch, busWord, 1'b1, data, ackFlag, errFlag);
    checkFlag("mscratch write ack", 1'b1, ackFlag);
    checkFlag("mscratch write err", 1'b0, errFlag);
    readExpect(csrPkg::addrMscratch, "mscratch", busWord);
    readExpect(csrPkg::addrMepc, "mepc", pc);
    readExpect(csrPkg::addrMcause, "mcause", 32'h0000_0002);
  endtask

  initial begin
    reset     <= 1'b1;
    cyc       <= 1'b0;
    stb       <= 1'b0;
    we        <= 1'b0;
    adr       <= '0;
    writeData <= '0;
    trap      <= 1'b0;
    trapPc    <= '0;
    trapCause <= '0;
    trapValue <= '0;
    mret      <= 1'b0;
    irq       <= 3'b000;
    mtvecModel = csrPkg::resetVector;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    testResetValues();
    testMaskedWrite();
    testErrors();
    testTrapReturn();
    testInterruptPending();
    testTrapPriority();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
